// ==== source/vdp_pkg.sv ====
package vdp_pkg;

    // ----------------------------------------------------------------------
    // colour and sprite geometry

    localparam int COLOR_WIDTH    = 12;   // 4 bits per channel, r g b
    localparam int SPRITE_SIZE    = 16;   // square edge in pixels
    localparam int COORD_WIDTH    = 16;   // sprite x / y register fields

    // ----------------------------------------------------------------------
    // register port

    localparam int       REG_ADDR_WIDTH = 1;
    localparam bit [0:0] REG_ADDR_POS   = 1'b0;   // sprite position
    localparam bit [0:0] REG_ADDR_ATTR  = 1'b1;   // enable and colours

    typedef struct packed
    {
        logic [COORD_WIDTH - 1:0] y;
        logic [COORD_WIDTH - 1:0] x;
    } vdp_pos_t;

    typedef struct packed
    {
        logic [6:0]               pad;
        logic                     en;
        logic [COLOR_WIDTH - 1:0] bg;
        logic [COLOR_WIDTH - 1:0] fg;
    } vdp_attr_t;

    // same write word, meaning picked by address
    typedef union packed
    {
        vdp_pos_t  pos;
        vdp_attr_t attr;
    } vdp_reg_word_t;

endpackage

// ==== source/vdp_hvsync.sv ====
`timescale 1ns/1ps

module vdp_hvsync
#(
    parameter N_VDP_PIPE = 2,
    parameter HPOS_WIDTH = 10,
    parameter VPOS_WIDTH = 10,

    parameter H_DISPLAY  = 640,   // visible pixels per line
    parameter H_FRONT    = 16,    // right border
    parameter H_SYNC     = 96,    // sync pulse width
    parameter H_BACK     = 48,    // left border

    parameter V_DISPLAY  = 480,   // visible lines
    parameter V_BOTTOM   = 10,
    parameter V_SYNC     = 2,
    parameter V_TOP      = 33
)
(
    input  logic                    clk,
    input  logic                    reset,
    output logic                    pix_en,
    output logic                    frame_start,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    display_on,
    output logic [HPOS_WIDTH - 1:0] hpos,
    output logic [VPOS_WIDTH - 1:0] vpos
);

    // sync window moved right to cover the pixel pipeline
    localparam H_SYNC_START = H_DISPLAY + H_FRONT + N_VDP_PIPE;
    localparam H_SYNC_END   = H_SYNC_START + H_SYNC - 1;
    localparam H_MAX        = H_DISPLAY + H_FRONT + H_SYNC + H_BACK - 1;   // line length unchanged

    localparam V_SYNC_START = V_DISPLAY + V_BOTTOM;
    localparam V_SYNC_END   = V_SYNC_START + V_SYNC - 1;
    localparam V_MAX        = V_SYNC_END + V_TOP;

    logic [HPOS_WIDTH - 1:0] d_hpos;
    logic [VPOS_WIDTH - 1:0] d_vpos;

    // ----------------------------------------------------------------------
    // next position

    always_comb
    begin
        if (hpos == H_MAX)
        begin
            d_hpos = '0;
            d_vpos = (vpos == V_MAX) ? '0 : vpos + 1'b1;
        end
        else
        begin
            d_hpos = hpos + 1'b1;
            d_vpos = vpos;
        end
    end

    // pixel rate is half the 50 MHz clock
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pix_en <= 1'b0;
        else
            pix_en <= ~pix_en;
    end

    assign frame_start = pix_en && d_hpos == '0 && d_vpos == '0;

    // ----------------------------------------------------------------------
    // registered outputs

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hsync      <= 1'b0;
            vsync      <= 1'b0;
            display_on <= 1'b0;
            hpos       <= '0;
            vpos       <= '0;
        end
        else if (pix_en)
        begin
            hsync      <= ~(d_hpos >= H_SYNC_START && d_hpos <= H_SYNC_END);
            vsync      <= ~(d_vpos >= V_SYNC_START && d_vpos <= V_SYNC_END);
            display_on <= d_hpos < H_DISPLAY && d_vpos < V_DISPLAY;
            hpos       <= d_hpos;
            vpos       <= d_vpos;
        end
    end

endmodule

// ==== source/vdp_regs.sv ====
`timescale 1ns/1ps

module vdp_regs
    import vdp_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pix_en,
    input  logic                        frame_start,
    input  logic                        reg_we,
    input  logic [REG_ADDR_WIDTH - 1:0] reg_addr,
    input  logic [31:0]                 reg_wdata,
    output logic [COORD_WIDTH - 1:0]    sprite_x,
    output logic [COORD_WIDTH - 1:0]    sprite_y,
    output logic                        sprite_en,
    output logic [COLOR_WIDTH - 1:0]    fg_color,
    output logic [COLOR_WIDTH - 1:0]    bg_color
);

    vdp_reg_word_t wword;

    // staged copies, written any time
    logic [COORD_WIDTH - 1:0] stg_x;
    logic [COORD_WIDTH - 1:0] stg_y;
    logic                     stg_en;
    logic [COLOR_WIDTH - 1:0] stg_fg;
    logic [COLOR_WIDTH - 1:0] stg_bg;

    assign wword = reg_wdata;

    // ----------------------------------------------------------------------
    // write port

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            stg_x  <= '0;
            stg_y  <= '0;
            stg_en <= 1'b0;
            stg_fg <= '0;
            stg_bg <= '0;
        end
        else if (reg_we)
        begin
            if (reg_addr == REG_ADDR_POS)
            begin
                stg_x <= wword.pos.x;
                stg_y <= wword.pos.y;
            end
            else if (reg_addr == REG_ADDR_ATTR)
            begin
                stg_en <= wword.attr.en;   // pad bits ignored
                stg_fg <= wword.attr.fg;
                stg_bg <= wword.attr.bg;
            end
        end
    end

    // ----------------------------------------------------------------------
    // whole set goes live at the top of the frame

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sprite_x  <= '0;
            sprite_y  <= '0;
            sprite_en <= 1'b0;
            fg_color  <= '0;
            bg_color  <= '0;
        end
        else if (pix_en && frame_start)
        begin
            sprite_x  <= stg_x;
            sprite_y  <= stg_y;
            sprite_en <= stg_en;
            fg_color  <= stg_fg;
            bg_color  <= stg_bg;
        end
    end

endmodule

// ==== source/vdp_sprite.sv ====
`timescale 1ns/1ps

module vdp_sprite
    import vdp_pkg::*;
#(
    parameter HPOS_WIDTH = 10,
    parameter VPOS_WIDTH = 10
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pix_en,
    input  logic [HPOS_WIDTH - 1:0]  hpos,
    input  logic [VPOS_WIDTH - 1:0]  vpos,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     display_on,
    input  logic [COORD_WIDTH - 1:0] sprite_x,
    input  logic [COORD_WIDTH - 1:0] sprite_y,
    input  logic                     sprite_en,
    output logic                     hit_d,
    output logic                     hsync_d,
    output logic                     vsync_d,
    output logic                     display_on_d
);

    // one extra bit so a corner near the top of the range cannot wrap
    logic [COORD_WIDTH:0] x_pos;
    logic [COORD_WIDTH:0] y_pos;
    logic [COORD_WIDTH:0] x_end;
    logic [COORD_WIDTH:0] y_end;
    logic                 x_in;
    logic                 y_in;
    logic                 hit;

    // ----------------------------------------------------------------------
    // hit test

    assign x_pos = (COORD_WIDTH + 1)'(hpos);
    assign y_pos = (COORD_WIDTH + 1)'(vpos);
    assign x_end = {1'b0, sprite_x} + (COORD_WIDTH + 1)'(SPRITE_SIZE);
    assign y_end = {1'b0, sprite_y} + (COORD_WIDTH + 1)'(SPRITE_SIZE);

    assign x_in = x_pos >= {1'b0, sprite_x} && x_pos < x_end;
    assign y_in = y_pos >= {1'b0, sprite_y} && y_pos < y_end;
    assign hit  = sprite_en && x_in && y_in;

    // ----------------------------------------------------------------------
    // stage 1 registers, sync and enable ride along

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hit_d        <= 1'b0;
            hsync_d      <= 1'b0;
            vsync_d      <= 1'b0;
            display_on_d <= 1'b0;
        end
        else if (pix_en)
        begin
            hit_d        <= hit;
            hsync_d      <= hsync;
            vsync_d      <= vsync;
            display_on_d <= display_on;
        end
    end

endmodule

// ==== source/vdp_pixel.sv ====
`timescale 1ns/1ps

module vdp_pixel
    import vdp_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pix_en,
    input  logic                           hit_d,
    input  logic                           hsync_d,
    input  logic                           vsync_d,
    input  logic                           display_on_d,
    input  logic [COLOR_WIDTH - 1:0]       fg_color,
    input  logic [COLOR_WIDTH - 1:0]       bg_color,
    output logic                           hsync,
    output logic                           vsync,
    output logic [COLOR_WIDTH / 3 - 1:0]   vga_r,
    output logic [COLOR_WIDTH / 3 - 1:0]   vga_g,
    output logic [COLOR_WIDTH / 3 - 1:0]   vga_b
);

    localparam CH = COLOR_WIDTH / 3;   // bits per channel

    logic [COLOR_WIDTH - 1:0] color_next;
    logic [COLOR_WIDTH - 1:0] color;

    // ----------------------------------------------------------------------
    // colour select

    always_comb
    begin
        if (!display_on_d)
            color_next = '0;               // black in blanking
        else if (hit_d)
            color_next = fg_color;
        else
            color_next = bg_color;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            color <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end
        else if (pix_en)
        begin
            color <= color_next;
            hsync <= hsync_d;
            vsync <= vsync_d;
        end
    end

    // red on top, blue at the bottom
    assign vga_r = color[3 * CH - 1:2 * CH];
    assign vga_g = color[2 * CH - 1:CH];
    assign vga_b = color[CH - 1:0];

endmodule

// ==== source/vdp_top.sv ====
`timescale 1ns/1ps

module vdp_top
    import vdp_pkg::*;
#(
    parameter HPOS_WIDTH = 10,
    parameter VPOS_WIDTH = 10,
    parameter H_DISPLAY  = 640,
    parameter H_FRONT    = 16,
    parameter H_SYNC     = 96,
    parameter H_BACK     = 48,
    parameter V_DISPLAY  = 480,
    parameter V_BOTTOM   = 10,
    parameter V_SYNC     = 2,
    parameter V_TOP      = 33,
    parameter N_VDP_PIPE = 2       // sprite stage plus pixel stage
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         reg_we,
    input  logic [REG_ADDR_WIDTH - 1:0]  reg_addr,
    input  logic [31:0]                  reg_wdata,
    output logic                         hsync,
    output logic                         vsync,
    output logic [COLOR_WIDTH / 3 - 1:0] vga_r,
    output logic [COLOR_WIDTH / 3 - 1:0] vga_g,
    output logic [COLOR_WIDTH / 3 - 1:0] vga_b
);

    logic                     pix_en;
    logic                     frame_start;
    logic                     pre_hsync;     // timing generator syncs
    logic                     pre_vsync;
    logic                     display_on;
    logic [HPOS_WIDTH - 1:0]  hpos;
    logic [VPOS_WIDTH - 1:0]  vpos;

    logic [COORD_WIDTH - 1:0] sprite_x;
    logic [COORD_WIDTH - 1:0] sprite_y;
    logic                     sprite_en;
    logic [COLOR_WIDTH - 1:0] fg_color;
    logic [COLOR_WIDTH - 1:0] bg_color;

    logic                     hit_d;
    logic                     hsync_d;
    logic                     vsync_d;
    logic                     display_on_d;

    // ----------------------------------------------------------------------
    // timing generator

    vdp_hvsync
    #(
        .N_VDP_PIPE (N_VDP_PIPE),
        .HPOS_WIDTH (HPOS_WIDTH),
        .VPOS_WIDTH (VPOS_WIDTH),
        .H_DISPLAY  (H_DISPLAY),
        .H_FRONT    (H_FRONT),
        .H_SYNC     (H_SYNC),
        .H_BACK     (H_BACK),
        .V_DISPLAY  (V_DISPLAY),
        .V_BOTTOM   (V_BOTTOM),
        .V_SYNC     (V_SYNC),
        .V_TOP      (V_TOP)
    )
    vdp_hvsync_i
    (
        .clk         (clk),
        .reset       (reset),
        .pix_en      (pix_en),
        .frame_start (frame_start),
        .hsync       (pre_hsync),
        .vsync       (pre_vsync),
        .display_on  (display_on),
        .hpos        (hpos),
        .vpos        (vpos)
    );

    vdp_regs vdp_regs_i
    (
        .clk         (clk),
        .reset       (reset),
        .pix_en      (pix_en),
        .frame_start (frame_start),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .sprite_x    (sprite_x),
        .sprite_y    (sprite_y),
        .sprite_en   (sprite_en),
        .fg_color    (fg_color),
        .bg_color    (bg_color)
    );

    // ----------------------------------------------------------------------
    // pixel pipeline

    vdp_sprite
    #(
        .HPOS_WIDTH (HPOS_WIDTH),
        .VPOS_WIDTH (VPOS_WIDTH)
    )
    vdp_sprite_i
    (
        .clk          (clk),
        .reset        (reset),
        .pix_en       (pix_en),
        .hpos         (hpos),
        .vpos         (vpos),
        .hsync        (pre_hsync),
        .vsync        (pre_vsync),
        .display_on   (display_on),
        .sprite_x     (sprite_x),
        .sprite_y     (sprite_y),
        .sprite_en    (sprite_en),
        .hit_d        (hit_d),
        .hsync_d      (hsync_d),
        .vsync_d      (vsync_d),
        .display_on_d (display_on_d)
    );

    vdp_pixel vdp_pixel_i
    (
        .clk          (clk),
        .reset        (reset),
        .pix_en       (pix_en),
        .hit_d        (hit_d),
        .hsync_d      (hsync_d),
        .vsync_d      (vsync_d),
        .display_on_d (display_on_d),
        .fg_color     (fg_color),
        .bg_color     (bg_color),
        .hsync        (hsync),
        .vsync        (vsync),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );

endmodule

// ==== bench/vdp_checker.sv ====
`timescale 1ns/1ps

module vdp_checker
    import vdp_pkg::*;
#(
    parameter H_DISPLAY  = 640,
    parameter H_FRONT    = 16,
    parameter H_SYNC     = 96,
    parameter H_BACK     = 48,
    parameter V_DISPLAY  = 480,
    parameter V_BOTTOM   = 10,
    parameter V_SYNC     = 2,
    parameter V_TOP      = 33,
    parameter N_VDP_PIPE = 2
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         reg_we,
    input  logic [REG_ADDR_WIDTH - 1:0]  reg_addr,
    input  logic [31:0]                  reg_wdata,
    input  logic                         hsync,
    input  logic                         vsync,
    input  logic [COLOR_WIDTH / 3 - 1:0] vga_r,
    input  logic [COLOR_WIDTH / 3 - 1:0] vga_g,
    input  logic [COLOR_WIDTH / 3 - 1:0] vga_b,
    output int                           value_errors,
    output int                           width_errors
);

    // the sync shift does not change the line length
    localparam LINE_STEPS  = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    localparam FRAME_LINES = V_DISPLAY + V_BOTTOM + V_SYNC + V_TOP;
    localparam HS_FIRST    = H_DISPLAY + H_FRONT + N_VDP_PIPE;
    localparam VS_FIRST    = V_DISPLAY + V_BOTTOM;

    typedef struct packed
    {
        bit                       en;
        int                       x;
        int                       y;
        logic [COLOR_WIDTH - 1:0] fg;
        logic [COLOR_WIDTH - 1:0] bg;
    } sprite_set_t;

    // one position plus the register set of its frame
    typedef struct packed
    {
        bit          valid;
        int          h;
        int          v;
        sprite_set_t regs;
    } pix_entry_t;

    vdp_reg_word_t wr_word;
    sprite_set_t   staged;
    sprite_set_t   active;
    pix_entry_t    line_q [0:2];     // [0] at the counters, [2] at the pins
    bit            model_pix_en;
    bit            stepped;
    int            pos_h;
    int            pos_v;
    int            value_count = 0;
    int            width_count = 0;
    int            hs_low = 0;
    int            vs_low = 0;
    bit            hs_armed = 1'b0;
    bit            vs_armed = 1'b0;

    assign wr_word      = reg_wdata;
    assign value_errors = value_count;
    assign width_errors = width_count;

    function automatic bit hs_expected(input pix_entry_t e);
        return e.valid && !(e.h >= HS_FIRST && e.h < HS_FIRST + H_SYNC);
    endfunction

    function automatic bit vs_expected(input pix_entry_t e);
        return e.valid && !(e.v >= VS_FIRST && e.v < VS_FIRST + V_SYNC);
    endfunction

    function automatic logic [COLOR_WIDTH - 1:0] color_expected(input pix_entry_t e);
        bit on_sprite;
        on_sprite = e.regs.en && e.h >= e.regs.x && e.h < e.regs.x + SPRITE_SIZE
                    && e.v >= e.regs.y && e.v < e.regs.y + SPRITE_SIZE;
        if (!e.valid || e.h >= H_DISPLAY || e.v >= V_DISPLAY)
            return '0;
        return on_sprite ? e.regs.fg : e.regs.bg;
    endfunction

    task automatic check_value(input string name, input int expected, input int got);
        if (expected != got)
        begin
            value_count++;
            $display("Error %0t: %s expected %0h got %0h", $time, name, expected, got);
        end
    endtask

    task automatic track_low_width(input string name, input logic level, input int expected,
                                   inout bit armed, inout int low_steps);
        if (!level)
        begin
            if (armed)
                low_steps++;
        end
        else
        begin
            if (armed && low_steps != 0 && low_steps != expected)
            begin
                width_count++;
                $display("Error %0t: %s low width expected %0d got %0d",
                         $time, name, expected, low_steps);
            end
            low_steps = 0;
            armed     = 1'b1;     // the low level out of reset is not a pulse
        end
    endtask

    // ----------------------------------------------------------------------
    // model advances on the rising edge

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            model_pix_en = 1'b0;
            stepped      = 1'b0;
            pos_h        = 0;
            pos_v        = 0;
            staged       = '0;
            active       = '0;
            for (int i = 0; i < 3; i++)
                line_q[i] = '0;
        end
        else
        begin
            stepped      = model_pix_en;
            model_pix_en = ~model_pix_en;
            if (stepped)
            begin
                line_q[2] = line_q[1];
                line_q[1] = line_q[0];
                pos_h     = (pos_h + 1) % LINE_STEPS;
                if (pos_h == 0)
                    pos_v = (pos_v + 1) % FRAME_LINES;
                if (pos_h == 0 && pos_v == 0)
                    active = staged;            // whole set at the first pixel
                line_q[0].valid = 1'b1;
                line_q[0].h     = pos_h;
                line_q[0].v     = pos_v;
                line_q[0].regs  = active;
            end
            // staging sees the write after the frame copy of the same edge
            if (reg_we && reg_addr == REG_ADDR_POS)
            begin
                staged.x = int'(wr_word.pos.x);
                staged.y = int'(wr_word.pos.y);
            end
            else if (reg_we && reg_addr == REG_ADDR_ATTR)
            begin
                staged.en = wr_word.attr.en;
                staged.fg = wr_word.attr.fg;
                staged.bg = wr_word.attr.bg;
            end
        end
    end

    // ----------------------------------------------------------------------
    // outputs have settled by the falling edge

    always @(negedge clk)
    begin
        if (reset)
            check_value("outputs in reset", 0, {hsync, vsync, vga_r, vga_g, vga_b});
        else if (stepped)
        begin
            check_value("hsync", hs_expected(line_q[2]), hsync);
            check_value("vsync", vs_expected(line_q[2]), vsync);
            check_value($sformatf("rgb at %0d,%0d", line_q[2].h, line_q[2].v),
                        color_expected(line_q[2]), {vga_r, vga_g, vga_b});
            track_low_width("hsync", hsync, H_SYNC, hs_armed, hs_low);
            track_low_width("vsync", vsync, V_SYNC * LINE_STEPS, vs_armed, vs_low);
        end
    end

endmodule

// ==== bench/tb_vdp.sv ====
`timescale 1ns/1ps

module tb_vdp
    import vdp_pkg::*;
();

    // small timing so a frame is short
    localparam H_DISPLAY   = 64;
    localparam H_FRONT     = 4;
    localparam H_SYNC      = 8;
    localparam H_BACK      = 4;
    localparam V_DISPLAY   = 48;
    localparam V_BOTTOM    = 2;
    localparam V_SYNC      = 2;
    localparam V_TOP       = 4;
    localparam N_VDP_PIPE  = 2;
    localparam HPOS_WIDTH  = 7;
    localparam VPOS_WIDTH  = 6;

    // ----------------------------------------------------------------------
    // run length

    localparam N_FRAMES       = 6;
    localparam LINE_STEPS     = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    localparam FRAME_LINES    = V_DISPLAY + V_BOTTOM + V_SYNC + V_TOP;
    localparam TIMEOUT_CYCLES = N_FRAMES * LINE_STEPS * FRAME_LINES * 2 + 200;
    localparam SEED           = 32'hd10cc275;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         reg_we;
    logic [REG_ADDR_WIDTH - 1:0]  reg_addr;
    logic [31:0]                  reg_wdata;
    logic                         hsync;
    logic                         vsync;
    logic [COLOR_WIDTH / 3 - 1:0] vga_r;
    logic [COLOR_WIDTH / 3 - 1:0] vga_g;
    logic [COLOR_WIDTH / 3 - 1:0] vga_b;

    int          value_errors;
    int          width_errors;
    int          writes = 0;
    int          gap;
    int          vs_falls = 0;
    logic        vs_prev = 1'b0;
    bit          frames_done = 1'b0;
    int          cycles = 0;

    always #2 clk = ~clk;   // 4 ns period

    vdp_top
    #(
        .HPOS_WIDTH (HPOS_WIDTH), .VPOS_WIDTH (VPOS_WIDTH),
        .H_DISPLAY  (H_DISPLAY),  .H_FRONT    (H_FRONT),
        .H_SYNC     (H_SYNC),     .H_BACK     (H_BACK),
        .V_DISPLAY  (V_DISPLAY),  .V_BOTTOM   (V_BOTTOM),
        .V_SYNC     (V_SYNC),     .V_TOP      (V_TOP),
        .N_VDP_PIPE (N_VDP_PIPE)
    )
    vdp_top_i
    (
        .clk (clk), .reset (reset), .reg_we (reg_we), .reg_addr (reg_addr),
        .reg_wdata (reg_wdata), .hsync (hsync), .vsync (vsync),
        .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b)
    );

    vdp_checker
    #(
        .H_DISPLAY  (H_DISPLAY),  .H_FRONT    (H_FRONT),
        .H_SYNC     (H_SYNC),     .H_BACK     (H_BACK),
        .V_DISPLAY  (V_DISPLAY),  .V_BOTTOM   (V_BOTTOM),
        .V_SYNC     (V_SYNC),     .V_TOP      (V_TOP),
        .N_VDP_PIPE (N_VDP_PIPE)
    )
    vdp_checker_i
    (
        .clk (clk), .reset (reset), .reg_we (reg_we), .reg_addr (reg_addr),
        .reg_wdata (reg_wdata), .hsync (hsync), .vsync (vsync),
        .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
        .value_errors (value_errors), .width_errors (width_errors)
    );

    task automatic drive_random_write();
        vdp_reg_word_t               word;
        logic [REG_ADDR_WIDTH - 1:0] addr;
        addr = $urandom_range(0, 1);
        if (addr == REG_ADDR_POS)
        begin
            // reaches past the 64x48 area, so some squares get clipped
            word.pos.x = 16'($urandom_range(0, 79));
            word.pos.y = 16'($urandom_range(0, 79));
        end
        else
        begin
            word.attr.pad = 7'($urandom);
            word.attr.en  = ($urandom_range(0, 3) != 0);   // off about one time in four
            word.attr.bg  = 12'($urandom);
            word.attr.fg  = 12'($urandom);
        end
        reg_addr  = addr;
        reg_wdata = word;
        reg_we    = 1'b1;
        writes++;
    endtask

    task automatic print_error_counts();
        $display("errors: %0d value, %0d sync width, %0d total, %0d writes",
                 value_errors, width_errors, value_errors + width_errors, writes);
    endtask

    // ----------------------------------------------------------------------
    // stimulus driven on the falling edge

    initial
    begin
        void'($urandom(SEED));
        reset      = 1'b1;
        reg_we     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        gap   = $urandom_range(200, 5900);   // about 3 writes per frame

        while (!frames_done)
        begin
            @(negedge clk);
            reg_we = 1'b0;
            if (vs_prev && !vsync)
                vs_falls++;
            if (!vs_prev && vsync && vs_falls == N_FRAMES)
                frames_done = 1'b1;           // last vsync pulse is over
            vs_prev = vsync;
            if (gap == 0)
            begin
                drive_random_write();
                gap = $urandom_range(200, 5900);
            end
            else
                gap--;
        end

        @(negedge clk);
        reg_we = 1'b0;
        repeat (4) @(negedge clk);
        print_error_counts();
        if (value_errors + width_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: simulation did not finish");
        print_error_counts();
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
source/vdp_pkg.sv
source/vdp_hvsync.sv
source/vdp_regs.sv
source/vdp_sprite.sv
source/vdp_pixel.sv
source/vdp_top.sv
bench/vdp_checker.sv
bench/tb_vdp.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the vdp testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f src.f --top-module tb_vdp -Mdir obj_dir -o tb_vdp
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_vdp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation passed"
exit 0
